//--- logic/issue_pkg.sv
package issue_pkg;

    // register address and program counter widths
    localparam int REG_W = 5;
    localparam int PC_W  = 64;

    // retire_pc when no trap or interrupt is taken
    localparam logic [PC_W-1:0] RETIRE_NONE = '1;

    // instruction class from decode
    typedef enum logic [2:0] {
        IC_ALU    = 3'd0,
        IC_MULDIV = 3'd1,
        IC_LSU    = 3'd2,
        IC_CSR    = 3'd3,
        IC_JUMP   = 3'd4,
        IC_TRAP   = 3'd5
    } iclass_e;

    // execution unit a slot is sent to
    typedef enum logic [1:0] {
        U_NONE = 2'd0,
        U_ALU0 = 2'd1,
        U_ALU1 = 2'd2,
        U_MMU  = 2'd3
    } unit_e;

endpackage

//--- logic/exec_unit.sv
module exec_unit #(
    parameter int BASE_LATENCY = 1,
    parameter int LONG_LATENCY = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  issue_pkg::iclass_e          start_class,
    input  logic [issue_pkg::REG_W-1:0] start_rd,
    output logic                        busy,
    output logic [issue_pkg::REG_W-1:0] dest,
    output logic                        wb_valid,
    output logic [issue_pkg::REG_W-1:0] wb_rd
);

    localparam int MAX_LATENCY = (LONG_LATENCY > BASE_LATENCY) ? LONG_LATENCY : BASE_LATENCY;
    localparam int CNT_W       = $clog2(MAX_LATENCY + 1);

    logic [CNT_W-1:0]            count;
    logic [CNT_W-1:0]            load_value;
    logic [issue_pkg::REG_W-1:0] rd_q;

    // muldiv runs the long path
    always_comb begin
        if (start_class == issue_pkg::IC_MULDIV) begin
            load_value = CNT_W'(LONG_LATENCY);
        end else begin
            load_value = CNT_W'(BASE_LATENCY);
        end
    end

    // a start in the last cycle reloads the down-counter directly
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= load_value;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rd_q <= start_rd;
        end
    end

    assign busy     = (count != '0);
    assign wb_valid = (count == CNT_W'(1));

    // destination only visible while occupied
    assign dest  = busy ? rd_q : '0;
    assign wb_rd = wb_valid ? rd_q : '0;

    // scoreboard may only start an idle unit or one in its writeback cycle
    start_when_free_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> (!busy || wb_valid)
    );

endmodule

//--- logic/issue_scoreboard.sv
module issue_scoreboard (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        slot0_valid,
    input  logic [issue_pkg::PC_W-1:0]  slot0_pc,
    input  issue_pkg::iclass_e          slot0_class,
    input  logic [issue_pkg::REG_W-1:0] slot0_rs1,
    input  logic                        slot0_rs1_en,
    input  logic [issue_pkg::REG_W-1:0] slot0_rs2,
    input  logic                        slot0_rs2_en,
    input  logic [issue_pkg::REG_W-1:0] slot0_rd,
    input  logic                        slot0_rd_en,
    input  logic                        slot1_valid,
    input  logic [issue_pkg::PC_W-1:0]  slot1_pc,
    input  issue_pkg::iclass_e          slot1_class,
    input  logic [issue_pkg::REG_W-1:0] slot1_rs1,
    input  logic                        slot1_rs1_en,
    input  logic [issue_pkg::REG_W-1:0] slot1_rs2,
    input  logic                        slot1_rs2_en,
    input  logic [issue_pkg::REG_W-1:0] slot1_rd,
    input  logic                        slot1_rd_en,
    input  logic                        timer_intr,
    input  logic                        alu0_busy,
    input  logic [issue_pkg::REG_W-1:0] alu0_dest,
    input  logic                        alu1_busy,
    input  logic [issue_pkg::REG_W-1:0] alu1_dest,
    input  logic                        mmu_busy,
    input  logic [issue_pkg::REG_W-1:0] mmu_dest,
    output logic                        slot0_issue,
    output logic                        slot1_issue,
    output issue_pkg::unit_e            slot0_unit,
    output issue_pkg::unit_e            slot1_unit,
    output logic                        slot0_squash,
    output logic                        slot1_squash,
    output logic                        trap_valid,
    output logic [issue_pkg::PC_W-1:0]  retire_pc,
    output logic                        alu0_start,
    output issue_pkg::iclass_e          alu0_start_class,
    output logic [issue_pkg::REG_W-1:0] alu0_start_rd,
    output logic                        alu1_start,
    output issue_pkg::iclass_e          alu1_start_class,
    output logic [issue_pkg::REG_W-1:0] alu1_start_rd,
    output logic                        mmu_start,
    output issue_pkg::iclass_e          mmu_start_class,
    output logic [issue_pkg::REG_W-1:0] mmu_start_rd
);

    // any enabled register of a slot equal to a live, nonzero destination
    function automatic logic slot_hit(
        input logic [issue_pkg::REG_W-1:0] rs1,
        input logic                        rs1_en,
        input logic [issue_pkg::REG_W-1:0] rs2,
        input logic                        rs2_en,
        input logic [issue_pkg::REG_W-1:0] rd,
        input logic                        rd_en,
        input logic                        live,
        input logic [issue_pkg::REG_W-1:0] dst
    );
        logic hit;
        hit = 1'b0;
        if (live && dst != '0) begin
            hit = (rs1_en && rs1 == dst) || (rs2_en && rs2 == dst) || (rd_en && rd == dst);
        end
        return hit;
    endfunction

    // fitting unit for a class given what is still free
    function automatic issue_pkg::unit_e pick_unit(
        input issue_pkg::iclass_e cls,
        input logic               a0_free,
        input logic               a1_free,
        input logic               m_free,
        input logic               quiet
    );
        issue_pkg::unit_e u;
        u = issue_pkg::U_NONE;
        case (cls)
            issue_pkg::IC_ALU, issue_pkg::IC_MULDIV, issue_pkg::IC_JUMP: begin
                if (a0_free) begin
                    u = issue_pkg::U_ALU0;
                end else if (a1_free) begin
                    u = issue_pkg::U_ALU1;
                end
            end
            issue_pkg::IC_CSR: begin
                if (a0_free) begin
                    u = issue_pkg::U_ALU0;
                end
            end
            issue_pkg::IC_LSU: begin
                if (m_free) begin
                    u = issue_pkg::U_MMU;
                end
            end
            // traps need the whole backend drained
            issue_pkg::IC_TRAP: begin
                if (quiet && a0_free) begin
                    u = issue_pkg::U_ALU0;
                end
            end
            default: u = issue_pkg::U_NONE;
        endcase
        return u;
    endfunction

    logic                        s1_older;
    logic                        all_idle;
    logic                        intr_take;

    logic                        o_valid;
    logic [issue_pkg::PC_W-1:0]  o_pc;
    issue_pkg::iclass_e          o_class;
    logic [issue_pkg::REG_W-1:0] o_rs1;
    logic                        o_rs1_en;
    logic [issue_pkg::REG_W-1:0] o_rs2;
    logic                        o_rs2_en;
    logic [issue_pkg::REG_W-1:0] o_rd;
    logic                        o_rd_en;
    logic                        o_busy_haz;
    issue_pkg::unit_e            o_pick;
    logic                        o_issue;
    issue_pkg::unit_e            o_unit;
    logic                        o_trap;
    logic                        o_jump;

    logic                        y_valid;
    issue_pkg::iclass_e          y_class;
    logic [issue_pkg::REG_W-1:0] y_rs1;
    logic                        y_rs1_en;
    logic [issue_pkg::REG_W-1:0] y_rs2;
    logic                        y_rs2_en;
    logic [issue_pkg::REG_W-1:0] y_rd;
    logic                        y_rd_en;
    logic                        y_busy_haz;
    logic                        y_pair_haz;
    logic                        y_kill;
    issue_pkg::unit_e            y_pick;
    logic                        y_issue;
    issue_pkg::unit_e            y_unit;
    logic                        y_squash;

    // an invalid slot never counts as the older one
    assign s1_older = slot1_valid && (!slot0_valid || (slot1_pc < slot0_pc));

    assign o_valid  = s1_older ? slot1_valid  : slot0_valid;
    assign o_pc     = s1_older ? slot1_pc     : slot0_pc;
    assign o_class  = s1_older ? slot1_class  : slot0_class;
    assign o_rs1    = s1_older ? slot1_rs1    : slot0_rs1;
    assign o_rs1_en = s1_older ? slot1_rs1_en : slot0_rs1_en;
    assign o_rs2    = s1_older ? slot1_rs2    : slot0_rs2;
    assign o_rs2_en = s1_older ? slot1_rs2_en : slot0_rs2_en;
    assign o_rd     = s1_older ? slot1_rd     : slot0_rd;
    assign o_rd_en  = s1_older ? slot1_rd_en  : slot0_rd_en;

    assign y_valid  = s1_older ? slot0_valid  : slot1_valid;
    assign y_class  = s1_older ? slot0_class  : slot1_class;
    assign y_rs1    = s1_older ? slot0_rs1    : slot1_rs1;
    assign y_rs1_en = s1_older ? slot0_rs1_en : slot1_rs1_en;
    assign y_rs2    = s1_older ? slot0_rs2    : slot1_rs2;
    assign y_rs2_en = s1_older ? slot0_rs2_en : slot1_rs2_en;
    assign y_rd     = s1_older ? slot0_rd     : slot1_rd;
    assign y_rd_en  = s1_older ? slot0_rd_en  : slot1_rd_en;

    assign all_idle  = !alu0_busy && !alu1_busy && !mmu_busy;
    assign intr_take = timer_intr && all_idle && o_valid;

    // older slot against the busy units
    assign o_busy_haz =
        slot_hit(o_rs1, o_rs1_en, o_rs2, o_rs2_en, o_rd, o_rd_en, alu0_busy, alu0_dest) ||
        slot_hit(o_rs1, o_rs1_en, o_rs2, o_rs2_en, o_rd, o_rd_en, alu1_busy, alu1_dest) ||
        slot_hit(o_rs1, o_rs1_en, o_rs2, o_rs2_en, o_rd, o_rd_en, mmu_busy, mmu_dest);

    assign o_pick  = pick_unit(o_class, !alu0_busy, !alu1_busy, !mmu_busy, all_idle);
    assign o_issue = o_valid && !o_busy_haz && !intr_take && (o_pick != issue_pkg::U_NONE);
    assign o_unit  = o_issue ? o_pick : issue_pkg::U_NONE;
    assign o_trap  = o_issue && (o_class == issue_pkg::IC_TRAP);
    assign o_jump  = o_issue && (o_class == issue_pkg::IC_JUMP);

    // younger slot sees the units left over after the older claim
    assign y_busy_haz =
        slot_hit(y_rs1, y_rs1_en, y_rs2, y_rs2_en, y_rd, y_rd_en, alu0_busy, alu0_dest) ||
        slot_hit(y_rs1, y_rs1_en, y_rs2, y_rs2_en, y_rd, y_rd_en, alu1_busy, alu1_dest) ||
        slot_hit(y_rs1, y_rs1_en, y_rs2, y_rs2_en, y_rd, y_rd_en, mmu_busy, mmu_dest);
    assign y_pair_haz =
        slot_hit(y_rs1, y_rs1_en, y_rs2, y_rs2_en, y_rd, y_rd_en, o_valid && o_rd_en, o_rd);

    assign y_kill = intr_take || o_trap || o_jump;
    assign y_pick = pick_unit(y_class,
                              !alu0_busy && (o_unit != issue_pkg::U_ALU0),
                              !alu1_busy && (o_unit != issue_pkg::U_ALU1),
                              !mmu_busy && (o_unit != issue_pkg::U_MMU),
                              all_idle && !o_issue);

    assign y_issue = y_valid && !y_kill && !y_busy_haz && !y_pair_haz &&
                     !(o_valid && !o_issue) && (y_pick != issue_pkg::U_NONE);
    assign y_unit   = y_issue ? y_pick : issue_pkg::U_NONE;
    assign y_squash = y_valid && y_kill;

    assign trap_valid = intr_take || o_trap;
    assign retire_pc  = (intr_take || o_trap) ? o_pc : issue_pkg::RETIRE_NONE;

    // back to slot order
    assign slot0_issue  = s1_older ? y_issue  : o_issue;
    assign slot1_issue  = s1_older ? o_issue  : y_issue;
    assign slot0_unit   = s1_older ? y_unit   : o_unit;
    assign slot1_unit   = s1_older ? o_unit   : y_unit;
    assign slot0_squash = s1_older ? y_squash : 1'b0;
    assign slot1_squash = s1_older ? 1'b0     : y_squash;

    assign alu0_start       = (o_unit == issue_pkg::U_ALU0) || (y_unit == issue_pkg::U_ALU0);
    assign alu0_start_class = (o_unit == issue_pkg::U_ALU0) ? o_class : y_class;
    assign alu0_start_rd    = (o_unit == issue_pkg::U_ALU0) ? (o_rd_en ? o_rd : '0) :
                                                              (y_rd_en ? y_rd : '0);

    assign alu1_start       = (o_unit == issue_pkg::U_ALU1) || (y_unit == issue_pkg::U_ALU1);
    assign alu1_start_class = (o_unit == issue_pkg::U_ALU1) ? o_class : y_class;
    assign alu1_start_rd    = (o_unit == issue_pkg::U_ALU1) ? (o_rd_en ? o_rd : '0) :
                                                              (y_rd_en ? y_rd : '0);

    assign mmu_start        = (o_unit == issue_pkg::U_MMU) || (y_unit == issue_pkg::U_MMU);
    assign mmu_start_class  = (o_unit == issue_pkg::U_MMU) ? o_class : y_class;
    assign mmu_start_rd     = (o_unit == issue_pkg::U_MMU) ? (o_rd_en ? o_rd : '0) :
                                                             (y_rd_en ? y_rd : '0);

    // both slots issuing must land on different units
    unit_unique_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (slot0_issue && slot1_issue) |-> (slot0_unit != slot1_unit)
    );

    issue_or_squash_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(slot0_issue && slot0_squash) && !(slot1_issue && slot1_squash)
    );

endmodule

//--- logic/issue_top.sv
module issue_top #(
    parameter int ALU_LATENCY    = 1,
    parameter int MULDIV_LATENCY = 4,
    parameter int MEM_LATENCY    = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        timer_intr,
    input  logic                        slot0_valid,
    input  logic [issue_pkg::PC_W-1:0]  slot0_pc,
    input  issue_pkg::iclass_e          slot0_class,
    input  logic [issue_pkg::REG_W-1:0] slot0_rs1,
    input  logic                        slot0_rs1_en,
    input  logic [issue_pkg::REG_W-1:0] slot0_rs2,
    input  logic                        slot0_rs2_en,
    input  logic [issue_pkg::REG_W-1:0] slot0_rd,
    input  logic                        slot0_rd_en,
    input  logic                        slot1_valid,
    input  logic [issue_pkg::PC_W-1:0]  slot1_pc,
    input  issue_pkg::iclass_e          slot1_class,
    input  logic [issue_pkg::REG_W-1:0] slot1_rs1,
    input  logic                        slot1_rs1_en,
    input  logic [issue_pkg::REG_W-1:0] slot1_rs2,
    input  logic                        slot1_rs2_en,
    input  logic [issue_pkg::REG_W-1:0] slot1_rd,
    input  logic                        slot1_rd_en,
    output logic                        slot0_issue,
    output logic                        slot1_issue,
    output issue_pkg::unit_e            slot0_unit,
    output issue_pkg::unit_e            slot1_unit,
    output logic                        slot0_squash,
    output logic                        slot1_squash,
    output logic                        trap_valid,
    output logic [issue_pkg::PC_W-1:0]  retire_pc,
    output logic                        alu0_wb_valid,
    output logic [issue_pkg::REG_W-1:0] alu0_wb_rd,
    output logic                        alu1_wb_valid,
    output logic [issue_pkg::REG_W-1:0] alu1_wb_rd,
    output logic                        mmu_wb_valid,
    output logic [issue_pkg::REG_W-1:0] mmu_wb_rd
);

    logic                        alu0_start;
    issue_pkg::iclass_e          alu0_start_class;
    logic [issue_pkg::REG_W-1:0] alu0_start_rd;
    logic                        alu0_busy;
    logic [issue_pkg::REG_W-1:0] alu0_dest;

    logic                        alu1_start;
    issue_pkg::iclass_e          alu1_start_class;
    logic [issue_pkg::REG_W-1:0] alu1_start_rd;
    logic                        alu1_busy;
    logic [issue_pkg::REG_W-1:0] alu1_dest;

    logic                        mmu_start;
    issue_pkg::iclass_e          mmu_start_class;
    logic [issue_pkg::REG_W-1:0] mmu_start_rd;
    logic                        mmu_busy;
    logic [issue_pkg::REG_W-1:0] mmu_dest;

    // port names match the local nets one to one
    issue_scoreboard u_scoreboard (.*);

    exec_unit #(
        .BASE_LATENCY (ALU_LATENCY),
        .LONG_LATENCY (MULDIV_LATENCY)
    ) u_alu0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (alu0_start),
        .start_class (alu0_start_class),
        .start_rd    (alu0_start_rd),
        .busy        (alu0_busy),
        .dest        (alu0_dest),
        .wb_valid    (alu0_wb_valid),
        .wb_rd       (alu0_wb_rd)
    );

    exec_unit #(
        .BASE_LATENCY (ALU_LATENCY),
        .LONG_LATENCY (MULDIV_LATENCY)
    ) u_alu1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (alu1_start),
        .start_class (alu1_start_class),
        .start_rd    (alu1_start_rd),
        .busy        (alu1_busy),
        .dest        (alu1_dest),
        .wb_valid    (alu1_wb_valid),
        .wb_rd       (alu1_wb_rd)
    );

    // memory unit has one latency whatever the class
    exec_unit #(
        .BASE_LATENCY (MEM_LATENCY),
        .LONG_LATENCY (MEM_LATENCY)
    ) u_mmu (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (mmu_start),
        .start_class (mmu_start_class),
        .start_rd    (mmu_start_rd),
        .busy        (mmu_busy),
        .dest        (mmu_dest),
        .wb_valid    (mmu_wb_valid),
        .wb_rd       (mmu_wb_rd)
    );

endmodule

//--- verif/issue_tb.sv
module issue_tb;

    localparam int N_VEC      = 22;
    localparam int N_FIELDS   = 10;
    localparam int ALU_LAT    = 1;
    localparam int MULDIV_LAT = 4;
    localparam int MEM_LAT    = 3;

    logic                        clk;
    logic                        rst_n;
    logic                        timer_intr;
    logic                        slot0_valid;
    logic                        slot1_valid;
    logic [issue_pkg::PC_W-1:0]  slot0_pc;
    logic [issue_pkg::PC_W-1:0]  slot1_pc;
    issue_pkg::iclass_e          slot0_class;
    issue_pkg::iclass_e          slot1_class;
    logic [issue_pkg::REG_W-1:0] slot0_rs1, slot0_rs2, slot0_rd;
    logic [issue_pkg::REG_W-1:0] slot1_rs1, slot1_rs2, slot1_rd;
    logic                        slot0_rs1_en, slot0_rs2_en, slot0_rd_en;
    logic                        slot1_rs1_en, slot1_rs2_en, slot1_rd_en;
    logic                        slot0_issue, slot1_issue, slot0_squash, slot1_squash;
    issue_pkg::unit_e            slot0_unit;
    issue_pkg::unit_e            slot1_unit;
    logic                        trap_valid;
    logic [issue_pkg::PC_W-1:0]  retire_pc;
    logic                        alu0_wb_valid, alu1_wb_valid, mmu_wb_valid;
    logic [issue_pkg::REG_W-1:0] alu0_wb_rd, alu1_wb_rd, mmu_wb_rd;

    logic [63:0] vec_mem [0:N_VEC*N_FIELDS-1];
    // expected writeback cycle and rd per unit, -1 when nothing is in flight
    int          due_cycle [3];
    logic [4:0]  due_rd [3];
    string       unit_name [3] = '{"alu0", "alu1", "mmu"};
    int          errors;
    logic        load_ok;

    issue_top u_issue_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(N_VEC * 4 + 200);
        $display("watchdog expired before all vectors were applied");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic int unit_latency(input int u, input logic [2:0] cls);
        int lat;
        lat = ALU_LAT;
        if (u == 2) begin
            lat = MEM_LAT;
        end else if (cls == 3'(issue_pkg::IC_MULDIV)) begin
            lat = MULDIV_LAT;
        end
        return lat;
    endfunction

    task automatic report_mismatch(input int idx, input string what,
                                   input logic [63:0] got, input logic [63:0] exp);
        $display("FAILED at %0t: vector %0d %s is %0h, expected %0h", $time, idx, what, got, exp);
        errors++;
    endtask

    // slot word: valid [28], class [26:24], then rs1, rs2, rd bytes with enable in bit 5
    task automatic apply_inputs(input logic [63:0] w0, input logic [63:0] pc0,
                                input logic [63:0] w1, input logic [63:0] pc1, input logic intr);
        slot0_valid  = w0[28];
        slot0_class  = issue_pkg::iclass_e'(w0[26:24]);
        slot0_rs1_en = w0[21];
        slot0_rs1    = w0[20:16];
        slot0_rs2_en = w0[13];
        slot0_rs2    = w0[12:8];
        slot0_rd_en  = w0[5];
        slot0_rd     = w0[4:0];
        slot0_pc     = pc0;
        slot1_valid  = w1[28];
        slot1_class  = issue_pkg::iclass_e'(w1[26:24]);
        slot1_rs1_en = w1[21];
        slot1_rs1    = w1[20:16];
        slot1_rs2_en = w1[13];
        slot1_rs2    = w1[12:8];
        slot1_rd_en  = w1[5];
        slot1_rd     = w1[4:0];
        slot1_pc     = pc1;
        timer_intr   = intr;
    endtask

    task automatic check_outputs(input int idx);
        logic [63:0] e0;
        logic [63:0] e1;
        int          b;
        b  = idx * N_FIELDS;
        e0 = vec_mem[b + 6];
        e1 = vec_mem[b + 7];
        if (slot0_issue !== e0[8])
            report_mismatch(idx, "slot0_issue", 64'(slot0_issue), 64'(e0[8]));
        if (slot0_unit !== e0[5:4])
            report_mismatch(idx, "slot0_unit", 64'(slot0_unit), 64'(e0[5:4]));
        if (slot0_squash !== e0[0])
            report_mismatch(idx, "slot0_squash", 64'(slot0_squash), 64'(e0[0]));
        if (slot1_issue !== e1[8])
            report_mismatch(idx, "slot1_issue", 64'(slot1_issue), 64'(e1[8]));
        if (slot1_unit !== e1[5:4])
            report_mismatch(idx, "slot1_unit", 64'(slot1_unit), 64'(e1[5:4]));
        if (slot1_squash !== e1[0])
            report_mismatch(idx, "slot1_squash", 64'(slot1_squash), 64'(e1[0]));
        if (trap_valid !== vec_mem[b + 8][0])
            report_mismatch(idx, "trap_valid", 64'(trap_valid), 64'(vec_mem[b + 8][0]));
        if (retire_pc !== vec_mem[b + 9])
            report_mismatch(idx, "retire_pc", retire_pc, vec_mem[b + 9]);
    endtask

    task automatic check_writeback(input int idx);
        logic       got_valid [3];
        logic [4:0] got_rd [3];
        logic       exp_valid;
        int         u;
        got_valid[0] = alu0_wb_valid;
        got_valid[1] = alu1_wb_valid;
        got_valid[2] = mmu_wb_valid;
        got_rd[0]    = alu0_wb_rd;
        got_rd[1]    = alu1_wb_rd;
        got_rd[2]    = mmu_wb_rd;
        for (u = 0; u < 3; u++) begin
            exp_valid = (due_cycle[u] == idx);
            if (got_valid[u] !== exp_valid)
                report_mismatch(idx, {unit_name[u], "_wb_valid"}, 64'(got_valid[u]),
                                64'(exp_valid));
            if (exp_valid && got_rd[u] !== due_rd[u])
                report_mismatch(idx, {unit_name[u], "_wb_rd"}, 64'(got_rd[u]), 64'(due_rd[u]));
        end
    endtask

    // an issue in cycle idx writes back latency cycles later
    task automatic record_issues(input int idx);
        logic [63:0] e;
        logic [63:0] w;
        int          s;
        int          u;
        for (s = 0; s < 2; s++) begin
            e = vec_mem[idx * N_FIELDS + 6 + s];
            w = vec_mem[idx * N_FIELDS + 1 + 2 * s];
            if (e[8]) begin
                u = int'(e[5:4]) - 1;
                due_cycle[u] = idx + unit_latency(u, w[26:24]);
                due_rd[u]    = w[5] ? w[4:0] : 5'd0;
            end
        end
    endtask

    initial begin
        int i;
        int b;
        int vec_err;
        int vec_pass;
        int vec_fail;
        int group_first;
        int group_fail;
        errors      = 0;
        vec_pass    = 0;
        vec_fail    = 0;
        group_first = 0;
        group_fail  = 0;
        for (i = 0; i < 3; i++) begin
            due_cycle[i] = -1;
            due_rd[i]    = 5'd0;
        end
        rst_n = 1'b0;
        apply_inputs('0, '0, '0, '0, 1'b0);
        $readmemh("verif/issue_vectors.txt", vec_mem);
        load_ok = !$isunknown(vec_mem[0]) && !$isunknown(vec_mem[N_VEC*N_FIELDS-1]);
        if (!load_ok) begin
            $display("could not read all vectors from verif/issue_vectors.txt");
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (i = 0; load_ok && i < N_VEC; i++) begin
            if (i != 0) begin
                @(posedge clk);
                #1;
            end
            b = i * N_FIELDS;
            apply_inputs(vec_mem[b + 1], vec_mem[b + 2], vec_mem[b + 3], vec_mem[b + 4],
                         vec_mem[b + 5][0]);
            // sample just before the next edge
            #2;
            vec_err = errors;
            check_outputs(i);
            check_writeback(i);
            record_issues(i);
            if (errors == vec_err) begin
                vec_pass++;
            end else begin
                vec_fail++;
            end
            if (i == N_VEC - 1 || vec_mem[b + N_FIELDS] != vec_mem[b]) begin
                $display("group %0d finished: %0d vectors, %0d failing", vec_mem[b],
                         i - group_first + 1, vec_fail - group_fail);
                group_first = i + 1;
                group_fail  = vec_fail;
            end
        end
        $display("vectors passed: %0d, vectors failed: %0d", vec_pass, vec_fail);
        if (load_ok && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- issue_top.f
logic/issue_pkg.sv
logic/exec_unit.sv
logic/issue_scoreboard.sv
logic/issue_top.sv
verif/issue_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= issue_tb
RTL_TOP    ?= issue_top
FILELIST   ?= issue_top.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "run failed"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then echo "run incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/issue_vectors.txt
// grp slot0 pc0 slot1 pc1 intr exp0 exp1 trap retire_pc
// slot = valid,class,rs1,rs2,rd (reg byte: bit5 enable); exp = issue,unit,squash
1 10212223 100 10242526 104 0 110 120 0 ffffffffffffffff
1 00000000 000 00000000 000 0 000 000 0 ffffffffffffffff
2 11212227 108 00000000 000 0 110 000 0 ffffffffffffffff
2 10270028 10c 10210023 110 0 000 000 0 ffffffffffffffff
2 00000000 000 10220020 110 0 000 120 0 ffffffffffffffff
2 12200020 114 00000000 000 0 130 000 0 ffffffffffffffff
2 10000027 10c 00000000 000 0 000 000 0 ffffffffffffffff
2 10270028 10c 00000000 000 0 110 000 0 ffffffffffffffff
3 10210029 200 1029002a 204 0 120 000 0 ffffffffffffffff
3 10220025 20c 10210025 208 0 000 110 0 ffffffffffffffff
3 10250026 210 10210022 214 0 000 000 0 ffffffffffffffff
4 12210022 300 12230024 304 0 130 000 0 ffffffffffffffff
4 11210026 308 00000000 000 0 110 000 0 ffffffffffffffff
4 13210027 30c 00000000 000 0 000 000 0 ffffffffffffffff
4 13210027 30c 00000000 000 0 000 000 0 ffffffffffffffff
5 14000021 400 10220023 404 0 120 001 0 ffffffffffffffff
6 15000000 500 00000000 000 0 000 000 0 ffffffffffffffff
6 15000000 500 10210022 504 0 110 001 1 500
6 10210023 600 10240025 604 1 120 000 0 ffffffffffffffff
6 00000000 000 00000000 000 1 000 000 0 ffffffffffffffff
6 10210022 70c 10230024 708 1 001 000 1 708
6 00000000 000 00000000 000 0 000 000 0 ffffffffffffffff
